// ==== source/tcm_pkg.sv ====
/*
 TCM memory map and geometry.
 Region bases decoded on the core port, the depth of each TCM
 and the width of one SRAM word.
 */
package tcm_pkg;

  // Region bases seen on the core port
  localparam logic [31:0] itcm_base = 32'h8000_0000;
  localparam logic [31:0] dtcm_base = 32'h9000_0000;

  // Address bits compared against a base
  localparam int region_msb = 31;
  localparam int region_lsb = 28;

  // Depth of each TCM in words
  localparam int itcm_words = 4096;
  localparam int dtcm_words = 2048;

  // Word geometry
  localparam int word_bytes = 4;
  localparam int word_bits  = 32;

endpackage

// ==== source/icb_pkg.sv ====
/*
 ICB channel payloads.
 One command struct and one response struct, shared by every link.
 */
package icb_pkg;

  // Command channel payload
  typedef struct packed {
    logic [31:0]                      addr;
    logic                             read;
    logic [tcm_pkg::word_bits-1:0]    wdata;
    logic [tcm_pkg::word_bytes-1:0]   wmask;
  } icb_cmd_t;

  // Response channel payload, rdata is zero on error
  typedef struct packed {
    logic                             err;
    logic [tcm_pkg::word_bits-1:0]    rdata;
  } icb_rsp_t;

endpackage

// ==== source/tcm_sram.sv ====
/*
 Single-port synchronous word RAM.
 Byte lane write enables, registered read data.
 */
`timescale 1ns/1ps

module tcm_sram #(
  parameter int words = 1024
) (
  input  logic                             clk,
  input  logic                             ram_cs,
  input  logic                             ram_we,
  input  logic [$clog2(words)-1:0]         ram_index,
  input  logic [tcm_pkg::word_bytes-1:0]   ram_wem,
  input  logic [tcm_pkg::word_bits-1:0]    ram_din,
  output logic [tcm_pkg::word_bits-1:0]    ram_dout
);

  logic [tcm_pkg::word_bits-1:0] mem [words];

  // Write enabled lanes, or register the addressed word on a read
  always_ff @(posedge clk) begin
    if (ram_cs) begin
      if (ram_we) begin
        for (int b = 0; b < tcm_pkg::word_bytes; b++) begin
          if (ram_wem[b]) begin
            mem[ram_index][8*b +: 8] <= ram_din[8*b +: 8];
          end
        end
      end else begin
        ram_dout <= mem[ram_index];
      end
    end
  end

endmodule

// ==== source/tcm_ctrl.sv ====
/*
 TCM controller.
 Turns ICB commands into SRAM accesses with a range check,
 returns the response one cycle later and holds it under back-pressure.
 */
`timescale 1ns/1ps

module tcm_ctrl #(
  parameter int words = 1024
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  icb_pkg::icb_cmd_t                cmd,
  output logic                             rsp_valid,
  input  logic                             rsp_ready,
  output icb_pkg::icb_rsp_t                rsp,
  output logic                             ram_cs,
  output logic                             ram_we,
  output logic [$clog2(words)-1:0]         ram_index,
  output logic [tcm_pkg::word_bytes-1:0]   ram_wem,
  output logic [tcm_pkg::word_bits-1:0]    ram_din,
  input  logic [tcm_pkg::word_bits-1:0]    ram_dout
);

  localparam int index_bits = $clog2(words);
  localparam int lane_bits  = $clog2(tcm_pkg::word_bytes);
  localparam logic [31:0] byte_limit = 32'(words * tcm_pkg::word_bytes);

  logic                          cmd_fire;
  logic                          in_range;
  logic                          rsp_err_q;
  logic                          rsp_read_q;
  logic                          rsp_first_q;
  logic [tcm_pkg::word_bits-1:0] hold_q;

  // New command only when no response is held or it leaves now
  assign cmd_ready = ~rsp_valid | rsp_ready;
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign in_range  = cmd.addr < byte_limit;

  // RAM port, lane bits of the offset are ignored
  assign ram_cs    = cmd_fire & in_range;
  assign ram_we    = ~cmd.read;
  assign ram_index = cmd.addr[lane_bits +: index_bits];
  assign ram_wem   = cmd.wmask;
  assign ram_din   = cmd.wdata;

  ////////////////////////////////////////////////////////////
  // Response state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid   <= 1'b0;
      rsp_err_q   <= 1'b0;
      rsp_read_q  <= 1'b0;
      rsp_first_q <= 1'b0;
    end else begin
      if (cmd_fire) begin
        rsp_valid  <= 1'b1;
        rsp_err_q  <= ~in_range;
        rsp_read_q <= cmd.read;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      rsp_first_q <= cmd_fire;
    end
  end

  // Capture RAM output once, it is used after the first response cycle
  always_ff @(posedge clk) begin
    if (rsp_first_q) begin
      hold_q <= ram_dout;
    end
  end

  always_comb begin
    rsp.err   = rsp_err_q;
    rsp.rdata = '0;
    if (rsp_read_q && !rsp_err_q) begin
      rsp.rdata = rsp_first_q ? ram_dout : hold_q;
    end
  end

  // Held response must not change, across the switch to hold_q
  rsp_stable: assert property (
    @(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
  );

endmodule

// ==== source/icb_arbiter.sv ====
/*
 Two-master ICB arbiter.
 Fixed priority to the external master, records the owner of each
 accepted command and routes its response back.
 */
`timescale 1ns/1ps

module icb_arbiter (
  input  logic                clk,
  input  logic                reset,
  // External agent
  input  logic                ext_cmd_valid,
  output logic                ext_cmd_ready,
  input  icb_pkg::icb_cmd_t   ext_cmd,
  output logic                ext_rsp_valid,
  input  logic                ext_rsp_ready,
  output icb_pkg::icb_rsp_t   ext_rsp,
  // Core side
  input  logic                core_cmd_valid,
  output logic                core_cmd_ready,
  input  icb_pkg::icb_cmd_t   core_cmd,
  output logic                core_rsp_valid,
  input  logic                core_rsp_ready,
  output icb_pkg::icb_rsp_t   core_rsp,
  // Toward the controller
  output logic                tcm_cmd_valid,
  input  logic                tcm_cmd_ready,
  output icb_pkg::icb_cmd_t   tcm_cmd,
  input  logic                tcm_rsp_valid,
  output logic                tcm_rsp_ready,
  input  icb_pkg::icb_rsp_t   tcm_rsp
);

  logic grant_ext;
  logic owner_valid_q;
  logic owner_ext_q;

  ////////////////////////////////////////////////////////////
  // Command grant
  ////////////////////////////////////////////////////////////

  // External wins whenever it requests
  assign grant_ext      = ext_cmd_valid;
  assign tcm_cmd_valid  = ext_cmd_valid | core_cmd_valid;
  assign tcm_cmd        = grant_ext ? ext_cmd : core_cmd;
  assign ext_cmd_ready  = grant_ext & tcm_cmd_ready;
  assign core_cmd_ready = ~grant_ext & tcm_cmd_ready;

  // Owner of the response the controller presents next
  always_ff @(posedge clk) begin
    if (reset) begin
      owner_valid_q <= 1'b0;
      owner_ext_q   <= 1'b0;
    end else if (tcm_cmd_valid && tcm_cmd_ready) begin
      owner_valid_q <= 1'b1;
      owner_ext_q   <= grant_ext;
    end else if (tcm_rsp_valid && tcm_rsp_ready) begin
      owner_valid_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////

  assign ext_rsp_valid  = tcm_rsp_valid & owner_ext_q;
  assign core_rsp_valid = tcm_rsp_valid & ~owner_ext_q;
  assign tcm_rsp_ready  = owner_ext_q ? ext_rsp_ready : core_rsp_ready;
  assign ext_rsp        = tcm_rsp;
  assign core_rsp       = tcm_rsp;

  owner_known: assert property (
    @(posedge clk) disable iff (reset)
    tcm_rsp_valid |-> owner_valid_q
  );

endmodule

// ==== source/icb_region_split.sv ====
/*
 Core port region decoder.
 Forwards ITCM and DTCM traffic as byte offsets and answers
 unmapped addresses locally with an error, one command outstanding.
 */
`timescale 1ns/1ps

module icb_region_split (
  input  logic                clk,
  input  logic                reset,
  // Core port, full addresses
  input  logic                core_cmd_valid,
  output logic                core_cmd_ready,
  input  icb_pkg::icb_cmd_t   core_cmd,
  output logic                core_rsp_valid,
  input  logic                core_rsp_ready,
  output icb_pkg::icb_rsp_t   core_rsp,
  // ITCM side
  output logic                itcm_cmd_valid,
  input  logic                itcm_cmd_ready,
  output icb_pkg::icb_cmd_t   itcm_cmd,
  input  logic                itcm_rsp_valid,
  output logic                itcm_rsp_ready,
  input  icb_pkg::icb_rsp_t   itcm_rsp,
  // DTCM side
  output logic                dtcm_cmd_valid,
  input  logic                dtcm_cmd_ready,
  output icb_pkg::icb_cmd_t   dtcm_cmd,
  input  logic                dtcm_rsp_valid,
  output logic                dtcm_rsp_ready,
  input  icb_pkg::icb_rsp_t   dtcm_rsp
);

  localparam int msb = tcm_pkg::region_msb;
  localparam int lsb = tcm_pkg::region_lsb;

  typedef enum logic [1:0] {
    tgt_none,
    tgt_itcm,
    tgt_dtcm,
    tgt_err
  } target_e;

  target_e pend_q;
  target_e cmd_target;
  logic    can_accept;
  logic    cmd_fire;
  logic    rsp_fire;

  ////////////////////////////////////////////////////////////
  // Decode and forward
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (core_cmd.addr[msb:lsb] == tcm_pkg::itcm_base[msb:lsb]) begin
      cmd_target = tgt_itcm;
    end else if (core_cmd.addr[msb:lsb] == tcm_pkg::dtcm_base[msb:lsb]) begin
      cmd_target = tgt_dtcm;
    end else begin
      cmd_target = tgt_err;
    end
  end

  // Strip the base so the TCM sees an offset
  always_comb begin
    itcm_cmd      = core_cmd;
    itcm_cmd.addr = core_cmd.addr - tcm_pkg::itcm_base;
    dtcm_cmd      = core_cmd;
    dtcm_cmd.addr = core_cmd.addr - tcm_pkg::dtcm_base;
  end

  assign rsp_fire   = core_rsp_valid & core_rsp_ready;
  assign can_accept = (pend_q == tgt_none) | rsp_fire;

  assign itcm_cmd_valid = core_cmd_valid & can_accept & (cmd_target == tgt_itcm);
  assign dtcm_cmd_valid = core_cmd_valid & can_accept & (cmd_target == tgt_dtcm);

  always_comb begin
    case (cmd_target)
      tgt_itcm: core_cmd_ready = can_accept & itcm_cmd_ready;
      tgt_dtcm: core_cmd_ready = can_accept & dtcm_cmd_ready;
      default:  core_cmd_ready = can_accept;
    endcase
  end

  assign cmd_fire = core_cmd_valid & core_cmd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= tgt_none;
    end else if (cmd_fire) begin
      pend_q <= cmd_target;
    end else if (rsp_fire) begin
      pend_q <= tgt_none;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response select
  ////////////////////////////////////////////////////////////

  assign itcm_rsp_ready = core_rsp_ready & (pend_q == tgt_itcm);
  assign dtcm_rsp_ready = core_rsp_ready & (pend_q == tgt_dtcm);

  always_comb begin
    core_rsp_valid = 1'b0;
    core_rsp       = '0;
    case (pend_q)
      tgt_itcm: begin
        core_rsp_valid = itcm_rsp_valid;
        core_rsp       = itcm_rsp;
      end
      tgt_dtcm: begin
        core_rsp_valid = dtcm_rsp_valid;
        core_rsp       = dtcm_rsp;
      end
      // Local error for an unmapped address
      tgt_err: begin
        core_rsp_valid = 1'b1;
        core_rsp.err   = 1'b1;
      end
      default: ;
    endcase
  end

  // Arbiters must only return core traffic that this split sent
  rsp_from_pending: assert property (
    @(posedge clk) disable iff (reset)
    (itcm_rsp_valid -> pend_q == tgt_itcm) && (dtcm_rsp_valid -> pend_q == tgt_dtcm)
  );

endmodule

// ==== source/tcm_subsys.sv ====
/*
 Tightly coupled memory subsystem.
 Core port split by region into ITCM and DTCM, each shared with an
 external agent through an arbiter, a controller and an SRAM.
 */
`timescale 1ns/1ps

module tcm_subsys (
  input  logic                clk,
  input  logic                reset,
  // Core port
  input  logic                core_cmd_valid,
  output logic                core_cmd_ready,
  input  icb_pkg::icb_cmd_t   core_cmd,
  output logic                core_rsp_valid,
  input  logic                core_rsp_ready,
  output icb_pkg::icb_rsp_t   core_rsp,
  // External agent to ITCM
  input  logic                ext_itcm_cmd_valid,
  output logic                ext_itcm_cmd_ready,
  input  icb_pkg::icb_cmd_t   ext_itcm_cmd,
  output logic                ext_itcm_rsp_valid,
  input  logic                ext_itcm_rsp_ready,
  output icb_pkg::icb_rsp_t   ext_itcm_rsp,
  // External agent to DTCM
  input  logic                ext_dtcm_cmd_valid,
  output logic                ext_dtcm_cmd_ready,
  input  icb_pkg::icb_cmd_t   ext_dtcm_cmd,
  output logic                ext_dtcm_rsp_valid,
  input  logic                ext_dtcm_rsp_ready,
  output icb_pkg::icb_rsp_t   ext_dtcm_rsp
);

  localparam int itcm_index_bits = $clog2(tcm_pkg::itcm_words);
  localparam int dtcm_index_bits = $clog2(tcm_pkg::dtcm_words);

  // Split to arbiters
  logic                          core_itcm_cmd_valid;
  logic                          core_itcm_cmd_ready;
  icb_pkg::icb_cmd_t             core_itcm_cmd;
  logic                          core_itcm_rsp_valid;
  logic                          core_itcm_rsp_ready;
  icb_pkg::icb_rsp_t             core_itcm_rsp;
  logic                          core_dtcm_cmd_valid;
  logic                          core_dtcm_cmd_ready;
  icb_pkg::icb_cmd_t             core_dtcm_cmd;
  logic                          core_dtcm_rsp_valid;
  logic                          core_dtcm_rsp_ready;
  icb_pkg::icb_rsp_t             core_dtcm_rsp;

  // Arbiters to controllers
  logic                          itcm_tcm_cmd_valid;
  logic                          itcm_tcm_cmd_ready;
  icb_pkg::icb_cmd_t             itcm_tcm_cmd;
  logic                          itcm_tcm_rsp_valid;
  logic                          itcm_tcm_rsp_ready;
  icb_pkg::icb_rsp_t             itcm_tcm_rsp;
  logic                          dtcm_tcm_cmd_valid;
  logic                          dtcm_tcm_cmd_ready;
  icb_pkg::icb_cmd_t             dtcm_tcm_cmd;
  logic                          dtcm_tcm_rsp_valid;
  logic                          dtcm_tcm_rsp_ready;
  icb_pkg::icb_rsp_t             dtcm_tcm_rsp;

  // RAM ports
  logic                          itcm_ram_cs;
  logic                          itcm_ram_we;
  logic [itcm_index_bits-1:0]    itcm_ram_index;
  logic [tcm_pkg::word_bytes-1:0] itcm_ram_wem;
  logic [tcm_pkg::word_bits-1:0] itcm_ram_din;
  logic [tcm_pkg::word_bits-1:0] itcm_ram_dout;
  logic                          dtcm_ram_cs;
  logic                          dtcm_ram_we;
  logic [dtcm_index_bits-1:0]    dtcm_ram_index;
  logic [tcm_pkg::word_bytes-1:0] dtcm_ram_wem;
  logic [tcm_pkg::word_bits-1:0] dtcm_ram_din;
  logic [tcm_pkg::word_bits-1:0] dtcm_ram_dout;

  ////////////////////////////////////////////////////////////
  // Core port decode
  ////////////////////////////////////////////////////////////

  icb_region_split region_split (
    .clk            (clk),
    .reset          (reset),
    .core_cmd_valid (core_cmd_valid),
    .core_cmd_ready (core_cmd_ready),
    .core_cmd       (core_cmd),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .core_rsp       (core_rsp),
    .itcm_cmd_valid (core_itcm_cmd_valid),
    .itcm_cmd_ready (core_itcm_cmd_ready),
    .itcm_cmd       (core_itcm_cmd),
    .itcm_rsp_valid (core_itcm_rsp_valid),
    .itcm_rsp_ready (core_itcm_rsp_ready),
    .itcm_rsp       (core_itcm_rsp),
    .dtcm_cmd_valid (core_dtcm_cmd_valid),
    .dtcm_cmd_ready (core_dtcm_cmd_ready),
    .dtcm_cmd       (core_dtcm_cmd),
    .dtcm_rsp_valid (core_dtcm_rsp_valid),
    .dtcm_rsp_ready (core_dtcm_rsp_ready),
    .dtcm_rsp       (core_dtcm_rsp)
  );

  ////////////////////////////////////////////////////////////
  // ITCM path
  ////////////////////////////////////////////////////////////

  icb_arbiter itcm_arb (
    .clk            (clk),
    .reset          (reset),
    .ext_cmd_valid  (ext_itcm_cmd_valid),
    .ext_cmd_ready  (ext_itcm_cmd_ready),
    .ext_cmd        (ext_itcm_cmd),
    .ext_rsp_valid  (ext_itcm_rsp_valid),
    .ext_rsp_ready  (ext_itcm_rsp_ready),
    .ext_rsp        (ext_itcm_rsp),
    .core_cmd_valid (core_itcm_cmd_valid),
    .core_cmd_ready (core_itcm_cmd_ready),
    .core_cmd       (core_itcm_cmd),
    .core_rsp_valid (core_itcm_rsp_valid),
    .core_rsp_ready (core_itcm_rsp_ready),
    .core_rsp       (core_itcm_rsp),
    .tcm_cmd_valid  (itcm_tcm_cmd_valid),
    .tcm_cmd_ready  (itcm_tcm_cmd_ready),
    .tcm_cmd        (itcm_tcm_cmd),
    .tcm_rsp_valid  (itcm_tcm_rsp_valid),
    .tcm_rsp_ready  (itcm_tcm_rsp_ready),
    .tcm_rsp        (itcm_tcm_rsp)
  );

  tcm_ctrl #(.words(tcm_pkg::itcm_words)) itcm_ctrl (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (itcm_tcm_cmd_valid),
    .cmd_ready (itcm_tcm_cmd_ready),
    .cmd       (itcm_tcm_cmd),
    .rsp_valid (itcm_tcm_rsp_valid),
    .rsp_ready (itcm_tcm_rsp_ready),
    .rsp       (itcm_tcm_rsp),
    .ram_cs    (itcm_ram_cs),
    .ram_we    (itcm_ram_we),
    .ram_index (itcm_ram_index),
    .ram_wem   (itcm_ram_wem),
    .ram_din   (itcm_ram_din),
    .ram_dout  (itcm_ram_dout)
  );

  tcm_sram #(.words(tcm_pkg::itcm_words)) itcm_ram (
    .clk       (clk),
    .ram_cs    (itcm_ram_cs),
    .ram_we    (itcm_ram_we),
    .ram_index (itcm_ram_index),
    .ram_wem   (itcm_ram_wem),
    .ram_din   (itcm_ram_din),
    .ram_dout  (itcm_ram_dout)
  );

  ////////////////////////////////////////////////////////////
  // DTCM path
  ////////////////////////////////////////////////////////////

  icb_arbiter dtcm_arb (
    .clk            (clk),
    .reset          (reset),
    .ext_cmd_valid  (ext_dtcm_cmd_valid),
    .ext_cmd_ready  (ext_dtcm_cmd_ready),
    .ext_cmd        (ext_dtcm_cmd),
    .ext_rsp_valid  (ext_dtcm_rsp_valid),
    .ext_rsp_ready  (ext_dtcm_rsp_ready),
    .ext_rsp        (ext_dtcm_rsp),
    .core_cmd_valid (core_dtcm_cmd_valid),
    .core_cmd_ready (core_dtcm_cmd_ready),
    .core_cmd       (core_dtcm_cmd),
    .core_rsp_valid (core_dtcm_rsp_valid),
    .core_rsp_ready (core_dtcm_rsp_ready),
    .core_rsp       (core_dtcm_rsp),
    .tcm_cmd_valid  (dtcm_tcm_cmd_valid),
    .tcm_cmd_ready  (dtcm_tcm_cmd_ready),
    .tcm_cmd        (dtcm_tcm_cmd),
    .tcm_rsp_valid  (dtcm_tcm_rsp_valid),
    .tcm_rsp_ready  (dtcm_tcm_rsp_ready),
    .tcm_rsp        (dtcm_tcm_rsp)
  );

  tcm_ctrl #(.words(tcm_pkg::dtcm_words)) dtcm_ctrl (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (dtcm_tcm_cmd_valid),
    .cmd_ready (dtcm_tcm_cmd_ready),
    .cmd       (dtcm_tcm_cmd),
    .rsp_valid (dtcm_tcm_rsp_valid),
    .rsp_ready (dtcm_tcm_rsp_ready),
    .rsp       (dtcm_tcm_rsp),
    .ram_cs    (dtcm_ram_cs),
    .ram_we    (dtcm_ram_we),
    .ram_index (dtcm_ram_index),
    .ram_wem   (dtcm_ram_wem),
    .ram_din   (dtcm_ram_din),
    .ram_dout  (dtcm_ram_dout)
  );

  tcm_sram #(.words(tcm_pkg::dtcm_words)) dtcm_ram (
    .clk       (clk),
    .ram_cs    (dtcm_ram_cs),
    .ram_we    (dtcm_ram_we),
    .ram_index (dtcm_ram_index),
    .ram_wem   (dtcm_ram_wem),
    .ram_din   (dtcm_ram_din),
    .ram_dout  (dtcm_ram_dout)
  );

endmodule

// ==== include/tcm_tb_util.svh ====
/*
 Testbench helpers.
 Galois LFSR for random bits and a word-array reference model.
 */
`ifndef TCM_TB_UTIL_SVH
`define TCM_TB_UTIL_SVH

localparam logic [31:0] lfsr_seed = 32'h9198_965d;

// Model word with a written flag per byte lane
typedef struct packed {
  logic [3:0]  lanes;
  logic [31:0] data;
} model_word_t;

// Right-shifting Galois LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
endfunction

// Take n bits with one LFSR step per bit
function automatic logic [31:0] lfsr_take(ref logic [31:0] state, input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    state = lfsr_step(state);
    bits  = {bits[30:0], state[0]};
  end
  return bits;
endfunction

// Apply a masked write to the model word
task automatic model_write(ref model_word_t mem [int], input int index,
                           input logic [31:0] wdata, input logic [3:0] wmask);
  model_word_t word;
  word = mem.exists(index) ? mem[index] : '0;
  for (int b = 0; b < 4; b++) begin
    if (wmask[b]) begin
      word.data[8*b +: 8] = wdata[8*b +: 8];
      word.lanes[b]       = 1'b1;
    end
  end
  mem[index] = word;
endtask

// Model word and the byte lanes ever written
task automatic model_read(ref model_word_t mem [int], input int index,
                          output logic [31:0] word, output logic [3:0] lanes);
  if (mem.exists(index)) begin
    word  = mem[index].data;
    lanes = mem[index].lanes;
  end else begin
    word  = 32'h0;
    lanes = 4'h0;
  end
endtask

`endif

// ==== bench/tcm_subsys_tb.sv ====
/*
 Testbench for the TCM subsystem.
 Three random ICB masters, a word-array reference model per TCM,
 per-port response checks and a watchdog.
 */
`timescale 1ns/1ps

module tcm_subsys_tb;

  `include "tcm_tb_util.svh"

  localparam int n_cmds = 300;
  // Each command must finish well inside 20 clock periods
  localparam int timeout_cycles = 3 * n_cmds * 20;

  // Expected response and the rdata lanes the model knows
  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
    logic [3:0]  lanes;
  } expect_t;

  logic clk;
  logic reset = 1'b1;

  // Port 0 core, port 1 ext ITCM, port 2 ext DTCM
  logic [2:0]        cmd_valid = '0;
  logic [2:0]        cmd_ready;
  icb_pkg::icb_cmd_t cmd [3] = '{default: '0};
  logic [2:0]        rsp_valid;
  logic [2:0]        rsp_ready = '1;
  icb_pkg::icb_rsp_t rsp [3];

  logic [31:0]       lfsr = lfsr_seed;
  model_word_t       itcm_mem [int];
  model_word_t       dtcm_mem [int];
  expect_t           exp_q [3][$];
  logic [2:0]        waiting = '0;
  logic [2:0]        rsp_due = '0;
  logic [2:0]        held_valid = '0;
  icb_pkg::icb_rsp_t held_rsp [3];
  int                issued [3] = '{default: 0};
  int                stall_left [3] = '{default: 0};
  int                accepted = 0;
  int                value_errors = 0;
  int                protocol_errors = 0;
  logic              all_done = 1'b0;

  tcm_subsys tcm_subsys_inst (
    .clk                (clk),
    .reset              (reset),
    .core_cmd_valid     (cmd_valid[0]),
    .core_cmd_ready     (cmd_ready[0]),
    .core_cmd           (cmd[0]),
    .core_rsp_valid     (rsp_valid[0]),
    .core_rsp_ready     (rsp_ready[0]),
    .core_rsp           (rsp[0]),
    .ext_itcm_cmd_valid (cmd_valid[1]),
    .ext_itcm_cmd_ready (cmd_ready[1]),
    .ext_itcm_cmd       (cmd[1]),
    .ext_itcm_rsp_valid (rsp_valid[1]),
    .ext_itcm_rsp_ready (rsp_ready[1]),
    .ext_itcm_rsp       (rsp[1]),
    .ext_dtcm_cmd_valid (cmd_valid[2]),
    .ext_dtcm_cmd_ready (cmd_ready[2]),
    .ext_dtcm_cmd       (cmd[2]),
    .ext_dtcm_rsp_valid (rsp_valid[2]),
    .ext_dtcm_rsp_ready (rsp_ready[2]),
    .ext_dtcm_rsp       (rsp[2])
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic string port_name(input int p);
    case (p)
      0:       return "core";
      1:       return "ext_itcm";
      default: return "ext_dtcm";
    endcase
  endfunction

  // TCM selected by a core address, -1 when unmapped
  function automatic int core_tcm(input logic [31:0] addr);
    if (addr[31:28] == tcm_pkg::itcm_base[31:28]) begin
      return 0;
    end
    if (addr[31:28] == tcm_pkg::dtcm_base[31:28]) begin
      return 1;
    end
    return -1;
  endfunction

  // Low window, last words, or just past the end of the TCM
  function automatic logic [31:0] pick_offset(input int words);
    logic [31:0] sel;
    logic [31:0] lane;
    logic [31:0] word;
    sel  = lfsr_take(lfsr, 2);
    lane = lfsr_take(lfsr, 2);
    case (sel)
      32'd2:   word = 32'(words - 4) + lfsr_take(lfsr, 2);
      32'd3:   word = 32'(words) + lfsr_take(lfsr, 3);
      default: word = lfsr_take(lfsr, 3);
    endcase
    return {word[29:0], 2'b00} + lane;
  endfunction

  function automatic icb_pkg::icb_cmd_t make_cmd(input int p);
    icb_pkg::icb_cmd_t c;
    logic [31:0]       region;
    logic [31:0]       r;
    if (p == 1) begin
      c.addr = pick_offset(tcm_pkg::itcm_words);
    end else if (p == 2) begin
      c.addr = pick_offset(tcm_pkg::dtcm_words);
    end else begin
      region = lfsr_take(lfsr, 2);
      case (region)
        32'd1:   c.addr = tcm_pkg::dtcm_base + pick_offset(tcm_pkg::dtcm_words);
        32'd3:   c.addr = 32'hA000_0000 + pick_offset(tcm_pkg::dtcm_words);
        default: c.addr = tcm_pkg::itcm_base + pick_offset(tcm_pkg::itcm_words);
      endcase
    end
    r       = lfsr_take(lfsr, 1);
    c.read  = r[0];
    c.wdata = lfsr_take(lfsr, 32);
    r       = lfsr_take(lfsr, 4);
    c.wmask = r[3:0];
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model applied in acceptance order
  ////////////////////////////////////////////////////////////

  task automatic accept_cmd(input int p, input icb_pkg::icb_cmd_t c);
    expect_t     e;
    logic [31:0] offset;
    logic [31:0] word;
    logic [3:0]  lanes;
    int          tcm;
    int          limit;
    tcm    = p - 1;
    offset = c.addr;
    if (p == 0) begin
      tcm = core_tcm(c.addr);
      if (tcm == 0) begin
        offset = c.addr - tcm_pkg::itcm_base;
      end else if (tcm == 1) begin
        offset = c.addr - tcm_pkg::dtcm_base;
      end
    end
    limit   = (tcm == 0) ? tcm_pkg::itcm_words * 4 : tcm_pkg::dtcm_words * 4;
    e.err   = 1'b1;
    e.rdata = '0;
    e.lanes = 4'hf;
    if (tcm >= 0 && offset < 32'(limit)) begin
      e.err = 1'b0;
      if (c.read && tcm == 0) begin
        model_read(itcm_mem, int'(offset >> 2), word, lanes);
      end else if (c.read) begin
        model_read(dtcm_mem, int'(offset >> 2), word, lanes);
      end else if (tcm == 0) begin
        model_write(itcm_mem, int'(offset >> 2), c.wdata, c.wmask);
      end else begin
        model_write(dtcm_mem, int'(offset >> 2), c.wdata, c.wmask);
      end
      if (c.read) begin
        e.rdata = word;
        e.lanes = lanes;
      end
    end
    exp_q[p].push_back(e);
  endtask

  task automatic check_rsp(input int p);
    expect_t     e;
    logic [31:0] keep;
    e = exp_q[p].pop_front();
    for (int b = 0; b < 4; b++) begin
      keep[8*b +: 8] = {8{e.lanes[b]}};
    end
    if (rsp[p].err !== e.err) begin
      $display("[ERROR] %0t ns %s_rsp.err expected %h actual %h",
               $time, port_name(p), e.err, rsp[p].err);
      value_errors++;
    end
    if ((rsp[p].rdata & keep) !== e.rdata) begin
      $display("[ERROR] %0t ns %s_rsp.rdata expected %h actual %h",
               $time, port_name(p), e.rdata, rsp[p].rdata);
      value_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Masters and monitors
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    if (!reset) begin
      // External agent wins its TCM over the core
      for (int t = 0; t < 2; t++) begin
        if (cmd_valid[0] && cmd_ready[0] && cmd_valid[t + 1]
            && core_tcm(cmd[0].addr) == t) begin
          $display("%0t ns: core command accepted ahead of a waiting %s command",
                   $time, port_name(t + 1));
          protocol_errors++;
        end
      end

      for (int p = 0; p < 3; p++) begin
        // Response must appear one clock after its command
        if (rsp_due[p] && !rsp_valid[p]) begin
          $display("%0t ns: %s response missing one clock after its command",
                   $time, port_name(p));
          protocol_errors++;
        end
        rsp_due[p] = 1'b0;

        // Held response must stay valid and unchanged
        if (held_valid[p] && !rsp_valid[p]) begin
          $display("%0t ns: %s response valid dropped before it was taken",
                   $time, port_name(p));
          protocol_errors++;
        end else if (held_valid[p] && rsp[p] !== held_rsp[p]) begin
          $display("[ERROR] %0t ns %s_rsp expected %h actual %h",
                   $time, port_name(p), held_rsp[p], rsp[p]);
          value_errors++;
        end
        held_valid[p] = rsp_valid[p] & ~rsp_ready[p];
        held_rsp[p]   = rsp[p];

        if (rsp_valid[p] && exp_q[p].size() == 0) begin
          $display("%0t ns: %s response valid with no command outstanding",
                   $time, port_name(p));
          protocol_errors++;
        end else if (rsp_valid[p] && rsp_ready[p]) begin
          check_rsp(p);
          waiting[p] = 1'b0;
        end

        if (cmd_valid[p] && cmd_ready[p]) begin
          accept_cmd(p, cmd[p]);
          waiting[p] = 1'b1;
          rsp_due[p] = 1'b1;
          accepted++;
          cmd_valid[p] <= 1'b0;
        end else if (!cmd_valid[p] && !waiting[p] && issued[p] < n_cmds) begin
          r = lfsr_take(lfsr, 1);
          if (r[0]) begin
            cmd[p]       <= make_cmd(p);
            cmd_valid[p] <= 1'b1;
            issued[p]++;
          end
        end

        // Response ready low for random stretches
        if (stall_left[p] > 0) begin
          rsp_ready[p] <= 1'b0;
          stall_left[p]--;
        end else begin
          r = lfsr_take(lfsr, 3);
          if (r[2:0] == 3'd0) begin
            r             = lfsr_take(lfsr, 3);
            stall_left[p] = int'(r);
            rsp_ready[p] <= 1'b0;
          end else begin
            rsp_ready[p] <= 1'b1;
          end
        end
      end
      all_done = (accepted == 3 * n_cmds) && (waiting == 3'b000);
    end
  end

  initial begin
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait (all_done);
    repeat (2) @(posedge clk);
    $display("Summary: %0d commands, %0d value errors, %0d protocol errors",
             accepted, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Watchdog timeout after %0d cycles with %0d commands accepted",
             timeout_cycles, accepted);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tcm_subsys.f ====
+incdir+include
source/tcm_pkg.sv
source/icb_pkg.sv
source/tcm_sram.sv
source/tcm_ctrl.sv
source/icb_arbiter.sv
source/icb_region_split.sv
source/tcm_subsys.sv
bench/tcm_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run of the TCM subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcm_subsys_tb
FILELIST  ?= tcm_subsys.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv bench/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, log in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
